//--- design/snakePkg.sv
`default_nettype none

package snakePkg;

    localparam int gridCols     = 14;
    localparam int gridRows     = 10;
    localparam int maxLength    = 50;
    localparam int maxObstacles = 15;
    localparam int mapCells     = gridCols * gridRows; // obstacle map width

    // column in the upper nibble, row in the lower nibble
    typedef logic [7:0] cellT;

    // index 0 is the head
    typedef cellT [maxLength-1:0] bodyT;

    typedef enum logic [1:0] {
        dirUp    = 2'b00,
        dirDown  = 2'b01,
        dirLeft  = 2'b10,
        dirRight = 2'b11
    } dirT;

    localparam cellT startCell   = 8'h75; // col 7, row 5
    localparam int   startLength = 3;

    // 4-bit wrap puts col 0/15 and row 0/11..15 outside the grid
    function automatic logic inGrid(cellT c);
        return (c[7:4] >= 4'd1) && (int'(c[7:4]) <= gridCols) &&
               (c[3:0] >= 4'd1) && (int'(c[3:0]) <= gridRows);
    endfunction

    function automatic int cellIndex(cellT c);
        return (int'(c[7:4]) - 1) + (int'(c[3:0]) - 1) * gridCols; // row major
    endfunction

endpackage

`default_nettype wire

//--- design/cellRandom.sv
`timescale 1ns/1ps
`default_nettype none

module cellRandom import snakePkg::*; (
    input  logic clk,
    input  logic nRst,
    output cellT randCell
);

    localparam logic [15:0] seed = 16'hACE1;
    localparam logic [15:0] tapMask = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1

    logic [15:0] lfsr;
    logic [3:0]  randCol;
    logic [3:0]  randRow;

    // galois form, shift right and fold the output bit back through the taps
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            lfsr <= seed;
        end else begin
            if (lfsr[0]) begin
                lfsr <= {1'b0, lfsr[15:1]} ^ tapMask;
            end else begin
                lfsr <= {1'b0, lfsr[15:1]};
            end
        end
    end

    // low byte picks the column, high byte the row, both kept legal
    always_comb begin
        randCol = 4'(int'(lfsr[7:0]) % gridCols + 1);
        randRow = 4'(int'(lfsr[15:8]) % gridRows + 1);
    end

    assign randCell = {randCol, randRow};

endmodule

`default_nettype wire

//--- design/headStepper.sv
`timescale 1ns/1ps
`default_nettype none

module headStepper import snakePkg::*; (
    input  logic clk,
    input  logic nRst,
    input  logic moveStrobe,
    input  dirT  dirIn,
    input  cellT head,
    input  logic moveDone,
    output logic stepValid,
    output cellT nextHead
);

    dirT        dir;
    dirT        moveDir;
    logic       busy;     // a move is in the pipeline
    logic       accept;
    logic [3:0] col;
    logic [3:0] row;
    cellT       stepped;

    assign accept = moveStrobe && !busy;
    assign col    = head[7:4];
    assign row    = head[3:0];

    // opposite directions share bit 1 and differ in bit 0
    assign moveDir = (dirIn[1] == dir[1] && dirIn[0] != dir[0]) ? dir : dirIn;

    always_comb begin
        case (moveDir)
            dirUp:    stepped = {col, row - 4'd1};
            dirDown:  stepped = {col, row + 4'd1};
            dirLeft:  stepped = {col - 4'd1, row};
            default:  stepped = {col + 4'd1, row}; // right
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            dir       <= dirRight;
            busy      <= 1'b0;
            stepValid <= 1'b0;
        end else begin
            stepValid <= accept;
            if (accept) begin
                dir  <= moveDir;
                busy <= 1'b1;
            end else if (moveDone) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            nextHead <= stepped; // may be off grid, stage 2 decides
        end
    end

endmodule

`default_nettype wire

//--- design/collisionCheck.sv
`timescale 1ns/1ps
`default_nettype none

module collisionCheck import snakePkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                stepValid,
    input  cellT                nextHead,
    input  bodyT                body,
    input  logic [7:0]          length,
    input  logic [mapCells-1:0] obstacleMap,
    input  cellT                foodCell,
    output logic                checkValid,
    output cellT                headOut,
    output logic                hitWall,
    output logic                hitSelf,
    output logic                hitObstacle,
    output logic                ateFood
);

    logic wallNext;
    logic selfNext;
    logic obstacleNext;

    assign wallNext = !inGrid(nextHead);

    // the tail segment leaves this move, so it is skipped
    always_comb begin
        selfNext = 1'b0;
        for (int i = 0; i < maxLength - 1; i++) begin
            if (i + 1 < int'(length) && body[i] == nextHead) begin
                selfNext = 1'b1;
            end
        end
    end

    assign obstacleNext = wallNext ? 1'b0 : obstacleMap[cellIndex(nextHead)];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            checkValid <= 1'b0;
        end else begin
            checkValid <= stepValid;
        end
    end

    // verdict only means something while checkValid is high
    always_ff @(posedge clk) begin
        if (stepValid) begin
            headOut     <= nextHead;
            hitWall     <= wallNext;
            hitSelf     <= selfNext;
            hitObstacle <= obstacleNext;
            ateFood     <= (nextHead == foodCell);
        end
    end

endmodule

`default_nettype wire

//--- design/bodyUpdate.sv
`timescale 1ns/1ps
`default_nettype none

module bodyUpdate import snakePkg::*; (
    input  logic       clk,
    input  logic       nRst,
    input  logic       checkValid,
    input  cellT       headIn,
    input  logic       hitWall,
    input  logic       hitSelf,
    input  logic       hitObstacle,
    input  logic       ateFood,
    output bodyT       body,
    output logic [7:0] length,
    output logic       gameOver,
    output logic       moveDone,
    output logic       foodEaten
);

    logic hit;
    logic live;  // verdict arrives and the game still runs

    assign hit  = hitWall || hitSelf || hitObstacle;
    assign live = checkValid && !gameOver;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            // start body runs leftward from the start cell
            for (int i = 0; i < maxLength; i++) begin
                if (i < startLength) begin
                    body[i] <= startCell - cellT'(i * 16);
                end else begin
                    body[i] <= '0;
                end
            end
            length    <= 8'(startLength);
            gameOver  <= 1'b0;
            moveDone  <= 1'b0;
            foodEaten <= 1'b0;
        end else begin
            moveDone  <= checkValid;            // fires even after game over
            foodEaten <= live && !hit && ateFood;
            if (live) begin
                if (hit) begin
                    gameOver <= 1'b1;             // held until reset
                end else begin
                    body <= {body[maxLength-2:0], headIn}; // old tail drops off the top
                    if (ateFood && int'(length) < maxLength) begin
                        length <= length + 8'd1;
                    end
                end
            end
        end
    end

    // entries at and beyond length are stale and never looked at,
    // growth exposes the old tail again, which is the right segment

endmodule

`default_nettype wire

//--- design/obstacleGen.sv
`timescale 1ns/1ps
`default_nettype none

module obstacleGen import snakePkg::*; (
    input  logic                clk,
    input  logic                nRst,
    input  logic                obstaclesOn,
    input  logic                foodEaten,
    input  cellT                randCell,
    input  bodyT                body,
    input  logic [7:0]          length,
    input  cellT                queryCell,
    output logic [mapCells-1:0] obstacleMap,
    output logic [3:0]          obstacleCount,
    output logic                obstacle
);

    logic       pending;     // a food was eaten, placement still owed
    logic       onBody;
    logic       nearHead;
    logic       crowded;
    logic       full;
    logic       tooDense;
    logic       candidateOk;
    logic [3:0] rc;
    logic [3:0] rr;
    logic [3:0] hc;
    logic [3:0] hr;

    function automatic logic mapBit(logic [mapCells-1:0] m, cellT c);
        return inGrid(c) ? m[cellIndex(c)] : 1'b0;
    endfunction

    assign rc = randCell[7:4];
    assign rr = randCell[3:0];
    assign hc = body[0][7:4];
    assign hr = body[0][3:0];

    always_comb begin
        onBody = 1'b0;
        for (int i = 0; i < maxLength; i++) begin
            if (i < int'(length) && body[i] == randCell) begin
                onBody = 1'b1;
            end
        end
    end

    // the four cells the head can step into next
    assign nearHead = (randCell == {hc, hr - 4'd1}) ||
                      (randCell == {hc, hr + 4'd1}) ||
                      (randCell == {hc - 4'd1, hr}) ||
                      (randCell == {hc + 4'd1, hr});

    // off-grid corners wrap to col/row 0 or past the edge and read as empty
    assign crowded = mapBit(obstacleMap, randCell) ||
                     mapBit(obstacleMap, {rc - 4'd1, rr - 4'd1}) ||
                     mapBit(obstacleMap, {rc + 4'd1, rr - 4'd1}) ||
                     mapBit(obstacleMap, {rc - 4'd1, rr + 4'd1}) ||
                     mapBit(obstacleMap, {rc + 4'd1, rr + 4'd1});

    assign full = int'(obstacleCount) >= maxObstacles;

    // keep obstacle count below roughly half the snake length
    assign tooDense = (int'(obstacleCount) * 2 + 2 >= int'(length) + 1) &&
                      (length >= 8'd4);

    assign candidateOk = !onBody && !nearHead && !crowded;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            obstacleMap   <= '0;
            obstacleCount <= 4'd0;
            pending       <= 1'b0;
        end else if (!obstaclesOn) begin
            obstacleMap   <= '0;
            obstacleCount <= 4'd0;
            pending       <= 1'b0;
        end else if (foodEaten) begin
            pending <= 1'b1;
        end else if (pending) begin
            if (full || tooDense) begin
                pending <= 1'b0;                    // placement skipped
            end else if (candidateOk) begin
                obstacleMap[cellIndex(randCell)] <= 1'b1;
                obstacleCount <= obstacleCount + 4'd1;
                pending       <= 1'b0;
            end
            // rejected cell, try the next random one
        end
    end

    assign obstacle = mapBit(obstacleMap, queryCell);

endmodule

`default_nettype wire

//--- design/snakeCore.sv
`timescale 1ns/1ps
`default_nettype none

module snakeCore import snakePkg::*; (
    input  logic       clk,
    input  logic       nRst,
    input  logic       moveStrobe,
    input  dirT        dirIn,
    input  cellT       foodCell,
    input  logic       obstaclesOn,
    input  cellT       queryCell,
    output bodyT       body,
    output logic [7:0] length,
    output logic       gameOver,
    output logic       moveDone,
    output logic [3:0] obstacleCount,
    output logic       obstacle
);

    logic                stepValid;
    cellT                nextHead;
    logic                checkValid;
    cellT                headOut;
    logic                hitWall;
    logic                hitSelf;
    logic                hitObstacle;
    logic                ateFood;
    logic                foodEaten;
    cellT                randCell;
    logic [mapCells-1:0] obstacleMap;

    cellRandom uRandom (
        .clk(clk), .nRst(nRst), .randCell(randCell)
    );

    headStepper uStepper (
        .clk(clk), .nRst(nRst), .moveStrobe(moveStrobe), .dirIn(dirIn),
        .head(body[0]), .moveDone(moveDone), .stepValid(stepValid), .nextHead(nextHead)
    );

    collisionCheck uCheck (
        .clk(clk), .nRst(nRst), .stepValid(stepValid), .nextHead(nextHead),
        .body(body), .length(length), .obstacleMap(obstacleMap), .foodCell(foodCell),
        .checkValid(checkValid), .headOut(headOut), .hitWall(hitWall),
        .hitSelf(hitSelf), .hitObstacle(hitObstacle), .ateFood(ateFood)
    );

    bodyUpdate uUpdate (
        .clk(clk), .nRst(nRst), .checkValid(checkValid), .headIn(headOut),
        .hitWall(hitWall), .hitSelf(hitSelf), .hitObstacle(hitObstacle),
        .ateFood(ateFood), .body(body), .length(length), .gameOver(gameOver),
        .moveDone(moveDone), .foodEaten(foodEaten)
    );

    obstacleGen uObstacles (
        .clk(clk), .nRst(nRst), .obstaclesOn(obstaclesOn), .foodEaten(foodEaten),
        .randCell(randCell), .body(body), .length(length), .queryCell(queryCell),
        .obstacleMap(obstacleMap), .obstacleCount(obstacleCount), .obstacle(obstacle)
    );

endmodule

`default_nettype wire

//--- verif/snakeAsserts_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module snakeAsserts import snakePkg::*; (
    input logic       clk,
    input logic       nRst,
    input logic       obstaclesOn,
    input logic [3:0] obstacleCount
);

    // at the limit the count holds instead of wrapping past it
    countLimit: assert property (@(posedge clk) disable iff (!nRst)
        obstaclesOn && obstacleCount == 4'(maxObstacles) |=>
        obstacleCount == 4'(maxObstacles))
        else $error("obstacle count went past the limit");

    // one placement per clock at most
    countStep: assert property (@(posedge clk) disable iff (!nRst)
        obstacleCount > $past(obstacleCount) |-> obstacleCount == $past(obstacleCount) + 4'd1)
        else $error("obstacle count rose by more than one");

    countClear: assert property (@(posedge clk) disable iff (!nRst)
        !obstaclesOn |=> obstacleCount == 4'd0)
        else $error("obstacle count not cleared after obstacles were switched off");

endmodule

bind obstacleGen snakeAsserts uAsserts (
    .clk(clk),
    .nRst(nRst),
    .obstaclesOn(obstaclesOn),
    .obstacleCount(obstacleCount)
);

`default_nettype wire

//--- verif/snakeTb.sv
`timescale 1ns/1ps
`default_nettype none

module snakeTb import snakePkg::*; ();

    logic       clk;
    logic       nRst;
    logic       moveStrobe;
    dirT        dirIn;
    cellT       foodCell;
    logic       obstaclesOn;
    cellT       queryCell;
    bodyT       body;
    logic [7:0] length;
    logic       gameOver;
    logic       moveDone;
    logic [3:0] obstacleCount;
    logic       obstacle;

    // reference model state
    bodyT        modelBody;
    int          modelLen;
    logic        modelOver;
    dirT         modelDir;
    logic        modelAte;
    logic        modelHitObst;
    logic [31:0] lcgState;
    string       testName;
    logic        seenMap [0:15][0:15]; // scanned obstacles by col and row
    int          seenCount;

    snakeCore UUT (
        .clk(clk), .nRst(nRst), .moveStrobe(moveStrobe), .dirIn(dirIn),
        .foodCell(foodCell), .obstaclesOn(obstaclesOn), .queryCell(queryCell),
        .body(body), .length(length), .gameOver(gameOver), .moveDone(moveDone),
        .obstacleCount(obstacleCount), .obstacle(obstacle)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic onGrid(cellT c);
        return c[7:4] != 4'd0 && int'(c[7:4]) <= gridCols &&
               c[3:0] != 4'd0 && int'(c[3:0]) <= gridRows;
    endfunction

    function automatic cellT stepCell(cellT c, dirT d);
        case (d)
            dirUp:   return {c[7:4], c[3:0] - 4'd1};
            dirDown: return {c[7:4], c[3:0] + 4'd1};
            dirLeft: return {c[7:4] - 4'd1, c[3:0]};
            default: return {c[7:4] + 4'd1, c[3:0]};
        endcase
    endfunction

    function automatic logic isReverse(dirT a, dirT b);
        return (a == dirUp && b == dirDown) || (a == dirDown && b == dirUp) ||
               (a == dirLeft && b == dirRight) || (a == dirRight && b == dirLeft);
    endfunction

    // tail segment is excluded as it moves away this step
    function automatic logic hitsBody(cellT c);
        for (int i = 0; i < modelLen - 1; i++) begin
            if (modelBody[i] == c) return 1'b1;
        end
        return 1'b0;
    endfunction

    // one move of the reference with the obstacle verdict from the query port
    function automatic void modelStep(dirT req, cellT food, logic obstHit);
        cellT h;
        if (!isReverse(req, modelDir)) modelDir = req;
        modelAte     = 1'b0;
        modelHitObst = 1'b0;
        if (modelOver) return;              // frozen body
        h = stepCell(modelBody[0], modelDir);
        if (!onGrid(h) || hitsBody(h) || obstHit) begin
            modelHitObst = onGrid(h) && !hitsBody(h) && obstHit;
            modelOver    = 1'b1;
            return;
        end
        modelBody = {modelBody[maxLength-2:0], h};
        if (h == food) begin
            modelAte = 1'b1;
            if (modelLen < maxLength) modelLen++;
        end
    endfunction

    function automatic dirT pickDir();
        logic [31:0] r;
        dirT         d;
        cellT        h;
        for (int t = 0; t < 16; t++) begin
            r = nextRand();
            d = dirT'(r[31:30]);
            h = stepCell(modelBody[0], d);
            if (!isReverse(d, modelDir) && onGrid(h) && !hitsBody(h) &&
                !seenMap[h[7:4]][h[3:0]]) return d;
        end
        return modelDir;
    endfunction

    // greedy walk toward target that detours around body and known obstacles
    function automatic dirT steerDir(cellT target);
        dirT  cand [0:5];
        cellT head;
        cellT h;
        head    = modelBody[0];
        cand[0] = (target[7:4] < head[7:4]) ? dirLeft : dirRight;
        cand[1] = (target[3:0] < head[3:0]) ? dirUp : dirDown;
        cand[2] = dirUp;
        cand[3] = dirDown;
        cand[4] = dirLeft;
        cand[5] = dirRight;
        for (int i = 0; i < 6; i++) begin
            h = stepCell(head, cand[i]);
            if (i == 0 && target[7:4] == head[7:4]) continue;
            if (i == 1 && target[3:0] == head[3:0]) continue;
            if (isReverse(cand[i], modelDir)) continue;
            if (h == target || (onGrid(h) && !hitsBody(h) && !seenMap[h[7:4]][h[3:0]])) begin
                return cand[i];
            end
        end
        return modelDir;
    endfunction

    task automatic abortRun(string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compareValue(string what, int expected, int actual);
        if (expected != actual) begin
            abortRun($sformatf("FAIL %s %s expected %0h actual %0h",
                               testName, what, expected, actual));
        end
    endtask

    task automatic applyReset(logic obstOn);
        @(posedge clk);
        nRst        <= 1'b0;
        moveStrobe  <= 1'b0;
        obstaclesOn <= obstOn;
        repeat (8) @(posedge clk);
        nRst <= 1'b1;
        modelBody = '0;
        for (int i = 0; i < startLength; i++) begin
            modelBody[i] = {startCell[7:4] - 4'(i), startCell[3:0]};
        end
        modelLen  = startLength;
        modelOver = 1'b0;
        modelDir  = dirRight;
        seenCount = 0;
        for (int c = 0; c < 16; c++) begin
            for (int r = 0; r < 16; r++) seenMap[c][r] = 1'b0;
        end
        @(posedge clk);
    endtask

    task automatic waitMoveDone();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!moveDone && n < 20);
        if (!moveDone) abortRun("moveDone did not arrive within 20 cycles");
    endtask

    task automatic waitCount(int target);
        int n;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (int'(obstacleCount) != target && n < 2000);
        if (int'(obstacleCount) != target) abortRun("obstacle placement timed out");
    endtask

    task automatic driveMove(dirT d, cellT food);
        dirT  eff;
        logic obstHit;
        eff = isReverse(d, modelDir) ? modelDir : d;
        queryCell <= stepCell(modelBody[0], eff); // ask the map before moving
        @(posedge clk);
        obstHit = obstacle;
        dirIn      <= d;
        foodCell   <= food;
        moveStrobe <= 1'b1;
        @(posedge clk);
        moveStrobe <= 1'b0;
        modelStep(d, food, obstHit);
        waitMoveDone();
    endtask

    task automatic scanObstacles();
        seenCount = 0;
        for (int c = 1; c <= gridCols; c++) begin
            for (int r = 1; r <= gridRows; r++) begin
                queryCell <= {4'(c), 4'(r)};
                @(posedge clk);
                seenMap[c][r] = obstacle;
                if (obstacle) seenCount++;
            end
        end
        compareValue("scanned count", int'(obstacleCount), seenCount);
        for (int i = 0; i < modelLen; i++) begin
            if (seenMap[modelBody[i][7:4]][modelBody[i][3:0]]) abortRun("obstacle on the body");
        end
        // off-grid entries stay zero so edges need no bounds
        for (int c = 1; c < gridCols; c++) begin
            for (int r = 1; r <= gridRows; r++) begin
                if (seenMap[c][r] && (seenMap[c+1][r-1] || seenMap[c+1][r+1])) begin
                    abortRun("two obstacles are diagonal neighbors");
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (nRst && moveDone) begin
            compareValue("length", modelLen, int'(length));
            compareValue("gameOver", int'(modelOver), int'(gameOver));
            for (int i = 0; i < modelLen; i++) begin
                compareValue($sformatf("body[%0d]", i), int'(modelBody[i]), int'(body[i]));
            end
        end
    end

    initial begin
        dirT  d;
        int   prevCount;
        cellT target;
        nRst        = 1'b0;
        moveStrobe  = 1'b0;
        dirIn       = dirRight;
        foodCell    = 8'h00;
        obstaclesOn = 1'b0;
        queryCell   = 8'h00;
        lcgState    = 32'he9d56289;

        testName = "reset";
        applyReset(1'b0);
        compareValue("length", startLength, int'(length));
        compareValue("gameOver", 0, int'(gameOver));
        compareValue("obstacleCount", 0, int'(obstacleCount));
        for (int i = 0; i < startLength; i++) begin
            compareValue($sformatf("body[%0d]", i), int'(modelBody[i]), int'(body[i]));
        end

        testName = "moves";
        driveMove(dirLeft, 8'h00);          // reverse of right so it keeps going right
        compareValue("head after reversal", 8'h85, int'(body[0]));
        for (int k = 0; k < 24; k++) driveMove(pickDir(), 8'h00);

        testName = "wall collision";
        applyReset(1'b0);
        for (int k = 0; k < 10 && !modelOver; k++) driveMove(dirRight, 8'h00);
        compareValue("gameOver", 1, int'(gameOver));
        driveMove(dirUp, 8'h00);

        testName = "growth";
        applyReset(1'b0);
        driveMove(dirRight, 8'h85);
        compareValue("length", 4, int'(length));
        driveMove(dirRight, 8'h95);
        compareValue("length", 5, int'(length));

        testName = "self collision";
        driveMove(dirDown, 8'h00);
        driveMove(dirLeft, 8'h00);
        driveMove(dirUp, 8'h00);            // lands on the fourth segment
        compareValue("gameOver", 1, int'(gameOver));
        driveMove(dirLeft, 8'h00);

        testName = "obstacles";
        applyReset(1'b1);
        for (int k = 0; k < 6; k++) begin
            d = pickDir();
            prevCount = int'(obstacleCount);
            driveMove(d, stepCell(modelBody[0], d)); // food right ahead
            if (modelAte && prevCount < maxObstacles &&
                !(prevCount * 2 + 2 >= modelLen + 1 && modelLen >= 4)) begin
                waitCount(prevCount + 1);
                scanObstacles();
            end else begin
                repeat (3) @(posedge clk);
                compareValue("skipped placement", prevCount, int'(obstacleCount));
            end
        end

        testName = "obstacle collision";
        target = 8'h00;
        for (int c = 1; c <= gridCols; c++) begin
            for (int r = 1; r <= gridRows; r++) begin
                if (seenMap[c][r] && target == 8'h00) target = {4'(c), 4'(r)};
            end
        end
        if (target == 8'h00) abortRun("no obstacle was placed");
        for (int k = 0; k < 60 && !modelOver; k++) driveMove(steerDir(target), 8'h00);
        if (!modelHitObst) abortRun("the snake never ran into the obstacle");
        compareValue("gameOver", 1, int'(gameOver));
        driveMove(dirDown, 8'h00);

        testName = "clearing";
        obstaclesOn <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        compareValue("obstacleCount", 0, int'(obstacleCount));
        scanObstacles();
        compareValue("scanned cells", 0, seenCount);

        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- Makefile
SOURCES := $(shell grep -v '^+' project.f)

obj_dir/VsnakeTb: project.f $(SOURCES)
	verilator --binary --assert -Wno-fatal --top-module snakeTb -f project.f -o VsnakeTb

run: obj_dir/VsnakeTb
	obj_dir/VsnakeTb | tee sim.log
	grep -q '^No errors$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

//--- project.f
design/snakePkg.sv
design/cellRandom.sv
design/headStepper.sv
design/collisionCheck.sv
design/bodyUpdate.sv
design/obstacleGen.sv
design/snakeCore.sv
verif/snakeAsserts_asserts.sv
verif/snakeTb.sv
